// ==== common/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

	//**************************************************
	// clock and line rates
	//**************************************************

	localparam int unsigned clk_freq = 49152000;   // sys_clk in hz
	localparam int unsigned bps_fast = 9600;       // baud_fast
	localparam int unsigned bps_slow = 4800;       // baud_slow

	//**************************************************
	// derived bit timing
	//**************************************************

	// sys_clk cycles per bit, 5120 and 10240
	localparam int unsigned bit_cycles_fast = clk_freq / bps_fast;
	localparam int unsigned bit_cycles_slow = clk_freq / bps_slow;

	// bit period counter width, wide enough for the slow rate
	localparam int unsigned cnt_w = 16;

	// start + 8 data + stop
	localparam int unsigned frame_bits = 10;

endpackage

// ==== common/uart_frame_pkg.sv ====
package uart_frame_pkg;

	//**************************************************
	// configuration
	//**************************************************

	// line rate select, shared by tx and rx
	typedef enum logic {
		baud_fast,          // 9600
		baud_slow           // 4800
	} baud_sel_e;

	//**************************************************
	// state machines
	//**************************************************

	typedef enum logic [1:0] {
		tx_idle,            // line high, waiting for tx_req
		tx_shift,           // start, data, stop bits on txd
		tx_hold             // tx_ack phase of handshake
	} tx_state_e;

	typedef enum logic [2:0] {
		rx_idle,            // waiting for falling edge
		rx_start,           // half bit, recheck start
		rx_data,            // 8 data bits at mid-bit
		rx_stop,            // stop bit sample
		rx_deliver          // hand off or drop
	} rx_state_e;

	//**************************************************
	// host side words
	//**************************************************

	typedef logic [7:0] uart_byte_t;

	typedef struct packed {
		uart_byte_t data;     // lsb received first
		logic framing_err;    // stop bit was low
		logic overrun;        // a frame was dropped before this one
	} rx_word_t;

endpackage

// ==== uart_tx/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx
	import uart_cfg_pkg::*, uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       master_rst,
	input  baud_sel_e  baud_sel,     // sampled at request
	input  logic       tx_req,       // host request, data held stable
	input  uart_byte_t tx_data,
	output logic       tx_ack,       // frame done
	output logic       txd           // serial out, idles high
);

	tx_state_e            state;
	baud_sel_e            baud_q;        // rate for the current frame
	uart_byte_t           data_q;        // latched word
	logic [cnt_w-1:0]     cnt;           // cycles within bit
	logic [3:0]           bit_idx;       // 0 start, 1..8 data, 9 stop
	logic [cnt_w-1:0]     bit_len;
	logic                 bit_end;
	logic                 start_go;
	logic [frame_bits-1:0] frame_vec;

	//**************************************************
	// bit timing
	//**************************************************

	assign bit_len = (baud_q == baud_fast) ? cnt_w'(bit_cycles_fast)
	                                       : cnt_w'(bit_cycles_slow);
	assign bit_end = (cnt == bit_len - 1'b1);     // last cycle of a bit

	// accepted only from idle, where tx_ack is already low
	assign start_go = (state == tx_idle) && tx_req;

	// frame laid out in send order, index = bit_idx
	assign frame_vec = {1'b1, data_q, 1'b0};

	// word buffer
	always_ff @(posedge sys_clk) begin
		if (start_go)
			data_q <= tx_data;
	end

	//**************************************************
	// control fsm and registered txd
	//**************************************************

	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			state   <= tx_idle;
			baud_q  <= baud_fast;
			cnt     <= '0;
			bit_idx <= '0;
			tx_ack  <= 1'b0;
			txd     <= 1'b1;              // line idle
		end else begin
			case (state)
				tx_idle: begin
					txd     <= 1'b1;
					cnt     <= '0;
					bit_idx <= '0;
					if (start_go) begin
						baud_q <= baud_sel;    // rate fixed for whole frame
						state  <= tx_shift;
					end
				end

				tx_shift: begin
					txd <= frame_vec[bit_idx];  // start bit shows one clock later
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == 4'(frame_bits - 1))
							state <= tx_hold;     // stop bit fully sent
						else
							bit_idx <= bit_idx + 4'd1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				tx_hold: begin
					txd <= 1'b1;                // back-pressure keeps line high
					if (!tx_ack) begin
						tx_ack <= 1'b1;         // 1 + 10 bit periods after request
					end else if (!tx_req) begin
						tx_ack <= 1'b0;         // host released, close handshake
						state  <= tx_idle;
					end
				end

				default: begin
					state <= tx_idle;
					txd   <= 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx
	import uart_cfg_pkg::*, uart_frame_pkg::*;
(
	input  logic      sys_clk,
	input  logic      master_rst,
	input  baud_sel_e baud_sel,      // sampled at start edge
	input  logic      rxd,           // async serial in
	output logic      rx_req,        // word ready
	input  logic      rx_ack,        // host took it
	output rx_word_t  rx_word        // held while rx_req high
);

	rx_state_e        state;
	baud_sel_e        baud_q;
	logic             rxd_meta;      // first sync stage
	logic             rxd_sync;      // second sync stage
	logic             rxd_prev;      // for edge detect
	logic             fall;
	logic [cnt_w-1:0] cnt;           // cycles since last sample point
	logic [2:0]       bit_idx;       // data bit 0..7
	logic [cnt_w-1:0] bit_len;
	logic             bit_end;
	logic             half_end;
	uart_byte_t       shift_q;       // data shifted in lsb first
	logic             stop_q;        // sampled stop level
	logic             overrun_q;     // dropped frame not yet reported
	logic             busy;
	logic             data_smp;
	logic             stop_smp;
	logic             deliver_go;

	//**************************************************
	// input synchronizer and start edge
	//**************************************************

	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			rxd_meta <= 1'b1;      // line idles high
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign fall = rxd_prev & ~rxd_sync;

	//**************************************************
	// sample timing
	//**************************************************

	assign bit_len  = (baud_q == baud_fast) ? cnt_w'(bit_cycles_fast)
	                                        : cnt_w'(bit_cycles_slow);
	assign bit_end  = (cnt == bit_len - 1'b1);            // one bit after last sample
	assign half_end = (cnt == (bit_len >> 1) - 1'b1);     // middle of start bit

	// handshake still open until host drops rx_ack
	assign busy = rx_req | rx_ack;

	assign data_smp   = (state == rx_data) && bit_end;
	assign stop_smp   = (state == rx_stop) && bit_end;
	assign deliver_go = (state == rx_deliver) && !busy;

	// payload path
	always_ff @(posedge sys_clk) begin
		if (data_smp)
			shift_q <= {rxd_sync, shift_q[7:1]};   // lsb arrives first
		if (stop_smp)
			stop_q <= rxd_sync;
		if (deliver_go)
			rx_word <= '{data: shift_q, framing_err: ~stop_q, overrun: overrun_q};
	end

	//**************************************************
	// receive fsm and delivery handshake
	//**************************************************

	always_ff @(posedge sys_clk) begin
		if (master_rst) begin
			state     <= rx_idle;
			baud_q    <= baud_fast;
			cnt       <= '0;
			bit_idx   <= '0;
			rx_req    <= 1'b0;
			overrun_q <= 1'b0;
		end else begin
			if (rx_req && rx_ack)
				rx_req <= 1'b0;                  // host saw it

			case (state)
				rx_idle: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (fall) begin
						baud_q <= baud_sel;
						state  <= rx_start;
					end
				end

				rx_start: begin
					if (half_end) begin
						cnt <= '0;
						// glitch if the line is back high
						state <= rxd_sync ? rx_idle : rx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				rx_data: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == 3'(frame_bits - 3))
							state <= rx_stop;      // all 8 bits in
						else
							bit_idx <= bit_idx + 3'd1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				rx_stop: begin
					if (bit_end) begin
						cnt   <= '0;
						state <= rx_deliver;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				rx_deliver: begin
					if (busy) begin
						overrun_q <= 1'b1;       // previous word still out, drop this one
					end else begin
						overrun_q <= 1'b0;       // reported with this word
						rx_req    <= 1'b1;
					end
					state <= rx_idle;            // half a stop bit left to catch next edge
				end

				default: state <= rx_idle;
			endcase
		end
	end

endmodule

// ==== hdl/uart_link_top.sv ====
`timescale 1ns/10ps

module uart_link_top
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       master_rst,
	input  baud_sel_e  baud_sel,     // change only while idle

	// transmit handshake
	input  logic       tx_req,
	input  uart_byte_t tx_data,
	output logic       tx_ack,

	// serial pins
	output logic       txd,
	input  logic       rxd,

	// receive handshake
	output logic       rx_req,
	input  logic       rx_ack,
	output rx_word_t   rx_word
);

	// transmitter
	uart_tx u_tx (
		.sys_clk    (sys_clk),
		.master_rst (master_rst),
		.baud_sel   (baud_sel),
		.tx_req     (tx_req),
		.tx_data    (tx_data),
		.tx_ack     (tx_ack),
		.txd        (txd)
	);

	// receiver, same rate
	uart_rx u_rx (
		.sys_clk    (sys_clk),
		.master_rst (master_rst),
		.baud_sel   (baud_sel),
		.rxd        (rxd),
		.rx_req     (rx_req),
		.rx_ack     (rx_ack),
		.rx_word    (rx_word)
	);

endmodule

// ==== tests/uart_link_props.sv ====
`timescale 1ns/10ps

module uart_link_props
	import uart_frame_pkg::*;
(
	input logic     sys_clk,
	input logic     master_rst,
	input logic     tx_req,
	input logic     tx_ack,
	input logic     txd,
	input logic     rx_req,
	input rx_word_t rx_word
);

	// ack only answers an open request
	tx_ack_needs_req: assert property (@(posedge sys_clk) disable iff (master_rst)
		$rose(tx_ack) |-> $past(tx_req))
		else $error("tx_ack rose without tx_req");

	// word held for the whole rx handshake
	rx_word_held: assert property (@(posedge sys_clk) disable iff (master_rst)
		(rx_req && $past(rx_req)) |-> $stable(rx_word))
		else $error("rx_word changed while rx_req was high");

	// no request and no ack means the transmitter sits idle
	txd_idle_high: assert property (@(posedge sys_clk) disable iff (master_rst)
		(!tx_req && !tx_ack) |-> txd)
		else $error("txd low while the transmitter was idle");

	rst_quiet: assert property (@(posedge sys_clk) master_rst |=> (!tx_ack && !rx_req))
		else $error("handshake outputs high after reset");

endmodule

// ==== tests/uart_link_tb.sv ====
`timescale 1ns/10ps

module uart_link_tb
	import uart_cfg_pkg::*, uart_frame_pkg::*;
();

	localparam int unsigned n_fast = 4;
	localparam int unsigned n_slow = 2;
	// fast frames: loopback, one bit-banged plus its idle bit, three for overrun
	localparam int unsigned frame_cyc = (n_fast + 5) * frame_bits * bit_cycles_fast
	                                  + n_slow * frame_bits * bit_cycles_slow;
	localparam int unsigned cyc_limit = frame_cyc * 3 / 2 + 1000;

	logic        sys_clk;
	logic        master_rst;
	baud_sel_e   baud_sel;
	logic        tx_req;
	uart_byte_t  tx_data;
	logic        tx_ack;
	logic        txd;
	logic        rxd;
	logic        rx_req;
	logic        rx_ack;
	rx_word_t    rx_word;

	logic        loopback_en;      // rxd follows txd
	logic        rxd_drv;          // bit-banged line
	logic        ack_hold;         // host stalls the rx handshake
	logic        ovr_pending;      // dropped frame not yet reported
	logic [31:0] lfsr_q;
	int unsigned cyc = 0;
	rx_word_t    exp_q[$];         // words the receiver should deliver

	assign rxd = loopback_en ? txd : rxd_drv;

	uart_link_top dut0 (.*);

	bind uart_link_top uart_link_props props0 (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;    // 4 ns
	end

	// run limit, scaled from the total frame time
	always @(posedge sys_clk) begin
		if (cyc >= cyc_limit)
			stop_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cyc));
		else
			cyc <= cyc + 1;
	end

	//**************************************************
	// reporting and compare
	//**************************************************

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input rx_word_t got, input rx_word_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: %s data %h fe %b ovr %b, expected %h %b %b",
				$time, what, got.data, got.framing_err, got.overrun,
				exp.data, exp.framing_err, exp.overrun));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_cycles(input int unsigned got, input int unsigned exp, input string what);
		if (got != exp)
			stop_run($sformatf("MISMATCH at %0t: %s %0d cycles, expected %0d",
				$time, what, got, exp));
	endtask

	//**************************************************
	// stimulus helpers and reference
	//**************************************************

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output uart_byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			b      = {lfsr_q[0], b[7:1]};   // one step per bit
		end
	endtask

	function automatic int unsigned bit_len(input baud_sel_e sel);
		return (sel == baud_slow) ? bit_cycles_slow : bit_cycles_fast;
	endfunction

	// expected delivery for one frame
	function automatic rx_word_t ref_word(input uart_byte_t b, input logic stop_bit,
	                                      input logic ovr);
		rx_word_t w;
		w.data        = b;
		w.framing_err = !stop_bit;      // stop must be high
		w.overrun     = ovr;            // an earlier frame was lost
		return w;
	endfunction

	// one frame through uart_tx, txd checked at every mid-bit
	task automatic send_byte(input uart_byte_t b, input logic check_lat);
		int unsigned bl;
		int unsigned req_cyc;
		logic [frame_bits-1:0] line;
		bl   = bit_len(baud_sel);
		line = {1'b1, b, 1'b0};          // start bit in lsb
		@(negedge sys_clk);
		tx_data = b;
		tx_req  = 1'b1;
		req_cyc = cyc + 1;               // sampled on next rising edge
		while (txd)
			@(negedge sys_clk);
		repeat (bl / 2) @(negedge sys_clk);
		for (int k = 0; k < frame_bits; k++) begin
			if (k != 0)
				repeat (bl) @(negedge sys_clk);
			check_bit(txd, line[0], $sformatf("txd bit %0d of %h", k, b));
			line = line >> 1;
		end
		while (!tx_ack)
			@(negedge sys_clk);
		if (check_lat)
			check_cycles(cyc - req_cyc, 1 + frame_bits * bl, "tx_ack latency");
		tx_req = 1'b0;
		while (tx_ack)
			@(negedge sys_clk);
	endtask

	// frame driven straight onto rxd, one idle bit after
	task automatic bang_frame(input uart_byte_t b, input logic stop_bit);
		int unsigned bl;
		logic [frame_bits-1:0] line;
		bl   = bit_len(baud_sel);
		line = {stop_bit, b, 1'b0};
		for (int k = 0; k <= frame_bits; k++) begin
			@(negedge sys_clk);
			rxd_drv = line[0];
			line    = {1'b1, line[frame_bits-1:1]};   // refills with idle
			repeat (bl - 1) @(negedge sys_clk);
		end
	endtask

	task automatic wait_rx_drain();
		while (exp_q.size() != 0 || rx_req || rx_ack)
			@(negedge sys_clk);
	endtask

	// receive host, compares each delivered word
	initial begin
		rx_ack = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (rx_req && !rx_ack && !ack_hold) begin
				if (exp_q.size() == 0) begin
					stop_run("receiver delivered a word that no test expected");
				end else begin
					check_word(rx_word, exp_q.pop_front(), "rx_word");
					rx_ack = 1'b1;
				end
			end else if (!rx_req && rx_ack) begin
				rx_ack = 1'b0;                 // close handshake
			end
		end
	end

	//**************************************************
	// test sequence
	//**************************************************

	initial begin
		uart_byte_t b;
		uart_byte_t held;
		master_rst  = 1'b1;
		baud_sel    = baud_fast;
		tx_req      = 1'b0;
		tx_data     = '0;
		loopback_en = 1'b1;
		rxd_drv     = 1'b1;
		ack_hold    = 1'b0;
		ovr_pending = 1'b0;
		lfsr_q      = 32'd66333;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		master_rst = 1'b0;
		check_bit(txd, 1'b1, "txd after reset");
		check_bit(tx_ack, 1'b0, "tx_ack after reset");
		check_bit(rx_req, 1'b0, "rx_req after reset");

		for (int i = 0; i < n_fast; i++) begin   // fast loopback
			rand_byte(b);
			exp_q.push_back(ref_word(b, 1'b1, ovr_pending));
			send_byte(b, 1'b0);
		end
		wait_rx_drain();

		@(negedge sys_clk);
		baud_sel = baud_slow;                      // link idle here
		for (int i = 0; i < n_slow; i++) begin
			rand_byte(b);
			exp_q.push_back(ref_word(b, 1'b1, ovr_pending));
			send_byte(b, 1'b1);
		end
		wait_rx_drain();

		// framing error, low stop bit on rxd
		baud_sel    = baud_fast;
		loopback_en = 1'b0;
		rand_byte(b);
		exp_q.push_back(ref_word(b, 1'b0, ovr_pending));
		bang_frame(b, 1'b0);
		wait_rx_drain();
		loopback_en = 1'b1;

		// overrun, second frame lands on an open handshake
		ack_hold = 1'b1;
		rand_byte(held);
		exp_q.push_back(ref_word(held, 1'b1, ovr_pending));
		send_byte(held, 1'b0);
		rand_byte(b);
		send_byte(b, 1'b0);                        // dropped by the receiver
		ovr_pending = 1'b1;
		ack_hold    = 1'b0;
		wait_rx_drain();
		rand_byte(b);
		exp_q.push_back(ref_word(b, 1'b1, ovr_pending));
		ovr_pending = 1'b0;
		send_byte(b, 1'b0);
		wait_rx_drain();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
common/uart_cfg_pkg.sv
common/uart_frame_pkg.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hdl/uart_link_top.sv
tests/uart_link_props.sv
tests/uart_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart link testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module uart_link_tb -Mdir obj_dir -f build.f

./obj_dir/Vuart_link_tb 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
